// ==== design/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        out_ready,
    output logic                        out_valid,
    output pipeline_types::bus32_t      out_pc,
    output pipeline_types::bus32_t      out_inst,
    output pipeline_types::inst_class_t out_class
);
    import pipeline_types::*;

    logic    wb_cyc;
    logic    wb_stb;
    bus32_t  wb_adr;
    logic    wb_ack;
    bus32_t  wb_dat;

    logic    rom_inst_en;
    bus32_t  rom_inst_addr;
    logic    uncache_en;
    bus32_t  uncache_addr;
    bus256_t rom_inst;
    logic    rom_inst_valid;
    bus32_t  uncache_inst;
    logic    uncache_valid;

    logic       push;
    bus32_t     push_pc;
    bus32_t     push_inst;
    logic [2:0] count;
    logic       pop;
    logic       head_valid;
    bus32_t     head_pc;
    bus32_t     head_inst;

    logic    redirect;
    bus32_t  redirect_pc;

    fetch_unit u_fetch (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat,
        .push, .push_pc, .push_inst, .count,
        .redirect, .redirect_pc
    );

    icache u_icache (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat,
        .rom_inst_en, .rom_inst_addr, .uncache_en, .uncache_addr,
        .rom_inst, .rom_inst_valid, .uncache_inst, .uncache_valid
    );

    inst_rom u_rom (
        .clk, .rst,
        .rom_inst_en, .rom_inst_addr, .uncache_en, .uncache_addr,
        .rom_inst, .rom_inst_valid, .uncache_inst, .uncache_valid
    );

    // a taken jump also empties the queue
    inst_queue u_queue (
        .clk, .rst,
        .push, .push_pc, .push_inst, .pop,
        .flush (redirect),
        .head_valid, .head_pc, .head_inst, .count
    );

    predecoder u_predecode (
        .head_valid, .head_pc, .head_inst, .pop,
        .out_valid, .out_pc, .out_inst, .out_class, .out_ready,
        .redirect, .redirect_pc
    );

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output pipeline_types::bus32_t wb_adr,
    input  logic                   wb_ack,
    input  pipeline_types::bus32_t wb_dat,
    output logic                   push,
    output pipeline_types::bus32_t push_pc,
    output pipeline_types::bus32_t push_inst,
    input  logic [2:0]             count,
    input  logic                   redirect,
    input  pipeline_types::bus32_t redirect_pc
);
    import pipeline_types::*;

    typedef enum logic {
        F_IDLE,
        F_BUSY
    } fetch_state_t;

    fetch_state_t state;
    bus32_t       pc_q;
    bus32_t       adr_q;
    logic         stale_q;
    logic         can_start;

    // keep a slot free for the word in flight
    assign can_start = (int'(count) + 1) <= QUEUE_DEPTH;

    assign wb_cyc    = (state == F_BUSY);
    assign wb_stb    = (state == F_BUSY);
    assign wb_adr    = adr_q;
    assign push      = (state == F_BUSY) && wb_ack && !stale_q && !redirect;
    assign push_pc   = adr_q;
    assign push_inst = wb_dat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= F_IDLE;
            pc_q    <= RESET_PC;
            stale_q <= 1'b0;
        end else if (state == F_IDLE) begin
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (can_start) begin
                state <= F_BUSY;
            end
        end else if (wb_ack) begin
            // cycle ends, cyc stays low for at least one cycle
            state   <= F_IDLE;
            stale_q <= 1'b0;
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (!stale_q) begin
                pc_q <= adr_q + 32'd4;
            end
        end else if (redirect) begin
            stale_q <= 1'b1;
            pc_q    <= redirect_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && !redirect && can_start) begin
            adr_q <= pc_q;
        end
    end

endmodule

// ==== design/icache.sv ====
`timescale 1ns/100ps

module icache (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  pipeline_types::bus32_t  wb_adr,
    output logic                    wb_ack,
    output pipeline_types::bus32_t  wb_dat,
    output logic                    rom_inst_en,
    output pipeline_types::bus32_t  rom_inst_addr,
    output logic                    uncache_en,
    output pipeline_types::bus32_t  uncache_addr,
    input  pipeline_types::bus256_t rom_inst,
    input  logic                    rom_inst_valid,
    input  pipeline_types::bus32_t  uncache_inst,
    input  logic                    uncache_valid
);
    import pipeline_types::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_REFILL_WAIT,
        S_UNCACHE_WAIT,
        S_RESPOND
    } state_t;

    state_t state;

    logic [ICACHE_TAG_BITS-1:0] tag_q [ICACHE_LINES];
    bus256_t                    data_q [ICACHE_LINES];
    logic [ICACHE_LINES-1:0]    valid_q;
    bus32_t                     resp_q;

    logic [ICACHE_INDEX_BITS-1:0]  idx;
    logic [ICACHE_TAG_BITS-1:0]    tag;
    logic [LINE_OFFSET_BITS-3:0]   word;
    logic                          uncached;
    logic                          hit;
    bus32_t                        hit_word;

    // address is held stable by the master until ack
    assign idx      = wb_adr[LINE_OFFSET_BITS +: ICACHE_INDEX_BITS];
    assign tag      = wb_adr[31 -: ICACHE_TAG_BITS];
    assign word     = wb_adr[LINE_OFFSET_BITS-1:2];
    assign uncached = (wb_adr[31:28] == UNCACHED_REGION);
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign hit_word = data_q[idx][word*32 +: 32];

    assign rom_inst_addr = {wb_adr[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    assign uncache_addr  = wb_adr;
    assign rom_inst_en   = (state == S_LOOKUP) && !uncached && !hit;
    assign uncache_en    = (state == S_LOOKUP) && uncached;

    // hits answer straight from the array
    assign wb_ack = ((state == S_LOOKUP) && !uncached && hit) || (state == S_RESPOND);
    assign wb_dat = (state == S_RESPOND) ? resp_q : hit_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (uncached) begin
                        state <= S_UNCACHE_WAIT;
                    end else if (hit) begin
                        state <= S_IDLE;
                    end else begin
                        state <= S_REFILL_WAIT;
                    end
                end
                S_REFILL_WAIT: begin
                    if (rom_inst_valid) begin
                        state <= S_RESPOND;
                    end
                end
                S_UNCACHE_WAIT: begin
                    if (uncache_valid) begin
                        state <= S_RESPOND;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (state == S_REFILL_WAIT && rom_inst_valid) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // line fill and response capture
    always_ff @(posedge clk) begin
        if (state == S_REFILL_WAIT && rom_inst_valid) begin
            data_q[idx] <= rom_inst;
            tag_q[idx]  <= tag;
            resp_q      <= rom_inst[word*32 +: 32];
        end else if (state == S_UNCACHE_WAIT && uncache_valid) begin
            resp_q <= uncache_inst;
        end
    end

endmodule

// ==== design/inst_queue.sv ====
`timescale 1ns/100ps

module inst_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  pipeline_types::bus32_t push_pc,
    input  pipeline_types::bus32_t push_inst,
    input  logic                   pop,
    input  logic                   flush,
    output logic                   head_valid,
    output pipeline_types::bus32_t head_pc,
    output pipeline_types::bus32_t head_inst,
    output logic [2:0]             count
);
    import pipeline_types::*;

    bus32_t pc_mem [QUEUE_DEPTH];
    bus32_t inst_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [2:0]                count_q;
    logic                      do_push;
    logic                      do_pop;

    assign do_pop  = pop && head_valid;
    // full queue takes a push only alongside a pop
    assign do_push = push && ((count_q != 3'(QUEUE_DEPTH)) || do_pop);

    assign head_valid = (count_q != 3'd0);
    assign head_pc    = pc_mem[rd_ptr];
    assign head_inst  = inst_mem[rd_ptr];
    assign count      = count_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count_q <= 3'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 3'd1;
                2'b01:   count_q <= count_q - 3'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
    end

endmodule

// ==== design/inst_rom.sv ====
`timescale 1ns/100ps

module inst_rom (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rom_inst_en,
    input  pipeline_types::bus32_t rom_inst_addr,
    input  logic                   uncache_en,
    input  pipeline_types::bus32_t uncache_addr,
    output pipeline_types::bus256_t rom_inst,
    output logic                   rom_inst_valid,
    output pipeline_types::bus32_t uncache_inst,
    output logic                   uncache_valid
);
    import pipeline_types::*;

    bus32_t rom [ROM_WORDS];

    logic [ROM_INDEX_BITS-1:0] line_idx;
    logic [ROM_INDEX_BITS-1:0] word_idx;

    initial begin
        $readmemh("tb/inst_rom.mem", rom);
    end

    // word index, upper address bits alias
    assign line_idx = rom_inst_addr[ROM_INDEX_BITS+1:2];
    assign word_idx = uncache_addr[ROM_INDEX_BITS+1:2];

    // line port, eight consecutive words
    always_ff @(posedge clk) begin
        if (rst || !rom_inst_en) begin
            rom_inst <= '0;
        end else begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                rom_inst[i*32 +: 32] <= rom[line_idx + ROM_INDEX_BITS'(i)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_inst_valid <= 1'b0;
            uncache_valid  <= 1'b0;
        end else begin
            rom_inst_valid <= rom_inst_en;
            uncache_valid  <= uncache_en;
        end
    end

    // single word port
    always_ff @(posedge clk) begin
        if (rst || !uncache_en) begin
            uncache_inst <= '0;
        end else begin
            uncache_inst <= rom[word_idx];
        end
    end

endmodule

// ==== design/pipeline_types.sv ====
package pipeline_types;

    typedef logic [31:0]  bus32_t;
    // word 0 sits in bits 31:0
    typedef logic [255:0] bus256_t;

    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD_STORE,
        CLASS_BRANCH,
        CLASS_JUMP,
        CLASS_OTHER
    } inst_class_t;

    // major opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_ALU_FIRST = 6'b000000,
        OP_ALU_LAST  = 6'b000111,
        OP_LD_ST     = 6'b001010,
        OP_LD_ST_X   = 6'b001110,
        OP_BR_FIRST  = 6'b010000,
        OP_B         = 6'b010100,
        OP_BR_LAST   = 6'b011011
    } opcode_t;

    localparam bus32_t     RESET_PC        = 32'h1c00_0000;
    localparam logic [3:0] UNCACHED_REGION = 4'ha;

    localparam int LINE_WORDS        = 8;
    localparam int LINE_OFFSET_BITS  = 5;
    localparam int ICACHE_LINES      = 16;
    localparam int ICACHE_INDEX_BITS = 4;
    localparam int ICACHE_TAG_BITS   = 32 - LINE_OFFSET_BITS - ICACHE_INDEX_BITS;
    localparam int QUEUE_DEPTH       = 4;
    localparam int QUEUE_PTR_BITS    = 2;
    localparam int ROM_WORDS         = 4096;
    localparam int ROM_INDEX_BITS    = 12;

endpackage

// ==== design/predecoder.sv ====
`timescale 1ns/100ps

module predecoder (
    input  logic                        head_valid,
    input  pipeline_types::bus32_t      head_pc,
    input  pipeline_types::bus32_t      head_inst,
    output logic                        pop,
    output logic                        out_valid,
    output pipeline_types::bus32_t      out_pc,
    output pipeline_types::bus32_t      out_inst,
    output pipeline_types::inst_class_t out_class,
    input  logic                        out_ready,
    output logic                        redirect,
    output pipeline_types::bus32_t      redirect_pc
);
    import pipeline_types::*;

    logic [5:0] opcode;
    bus32_t     offset;

    assign opcode = head_inst[31:26];

    // jump check comes first, it sits inside the branch range
    always_comb begin
        if (opcode == OP_B) begin
            out_class = CLASS_JUMP;
        end else if (opcode inside {[OP_ALU_FIRST:OP_ALU_LAST]}) begin
            out_class = CLASS_ALU;
        end else if (opcode inside {OP_LD_ST, OP_LD_ST_X}) begin
            out_class = CLASS_LOAD_STORE;
        end else if (opcode inside {[OP_BR_FIRST:OP_BR_LAST]}) begin
            out_class = CLASS_BRANCH;
        end else begin
            out_class = CLASS_OTHER;
        end
    end

    assign out_valid = head_valid;
    assign out_pc    = head_pc;
    assign out_inst  = head_inst;
    assign pop       = head_valid && out_ready;

    // signed word offset, scaled to bytes
    assign offset      = {{4{head_inst[25]}}, head_inst[25:0], 2'b00};
    assign redirect_pc = head_pc + offset;
    assign redirect    = pop && (out_class == CLASS_JUMP);

endmodule

// ==== tb/fetch_tb.sv ====
`timescale 1ns/100ps

module fetch_tb;
    import pipeline_types::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam bus32_t FILLER = 32'hdead_beef;

    logic        clk = 1'b0;
    logic        rst;
    logic        out_ready;
    logic        out_valid;
    bus32_t      out_pc;
    bus32_t      out_inst;
    inst_class_t out_class;

    // reference copy of the rom image
    bus32_t image [ROM_WORDS];

    bus32_t exp_pc;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     jumps_seen;
    int     uncached_seen;
    int     filler_seen;

    fetch_top dut (
        .clk,
        .rst,
        .out_ready,
        .out_valid,
        .out_pc,
        .out_inst,
        .out_class
    );

    always #2 clk = ~clk;

    // opcode ranges in bits 31:26
    function automatic inst_class_t expected_class(input bus32_t inst);
        logic [5:0] op;
        op = inst[31:26];
        if (op == 6'b010100) begin
            return CLASS_JUMP;
        end else if (op <= 6'b000111) begin
            return CLASS_ALU;
        end else if (op == 6'b001010 || op == 6'b001110) begin
            return CLASS_LOAD_STORE;
        end else if (op >= 6'b010000 && op <= 6'b011011) begin
            return CLASS_BRANCH;
        end
        return CLASS_OTHER;
    endfunction

    // next pc is pc+4 or the jump target
    function automatic bus32_t next_pc(input bus32_t pc, input bus32_t inst);
        logic signed [31:0] words;
        if (inst[31:26] == 6'b010100) begin
            words = {{6{inst[25]}}, inst[25:0]};
            return pc + bus32_t'(words * 4);
        end
        return pc + 32'd4;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #0.5;
        rst = 1'b1;
        out_ready = 1'b0;
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;
        exp_pc = RESET_PC;
        jumps_seen = 0;
        uncached_seen = 0;
        filler_seen = 0;
    endtask

    task automatic check_transfer(input bit check_class);
        bus32_t      exp_inst;
        inst_class_t exp_class;
        exp_inst = image[exp_pc[13:2]];
        exp_class = expected_class(exp_inst);
        assert (out_pc === exp_pc) else begin
            $display("[ERROR] out_pc: expected %h, got %h", exp_pc, out_pc);
            errors++;
        end
        assert (out_inst === exp_inst) else begin
            $display("[ERROR] out_inst: expected %h, got %h", exp_inst, out_inst);
            errors++;
        end
        if (check_class) begin
            assert (out_class === exp_class) else begin
                $display("[ERROR] out_class: expected %h, got %h", exp_class, out_class);
                errors++;
            end
        end
        if (exp_class == CLASS_JUMP) jumps_seen++;
        if (out_pc[31:28] == UNCACHED_REGION) uncached_seen++;
        if (out_inst === FILLER) filler_seen++;
        exp_pc = next_pc(exp_pc, exp_inst);
    endtask

    // transfer happens on the next edge when valid and ready are high at negedge
    task automatic take_transfers(input int n, input bit random_ready, input bit check_class);
        int done;
        int idle;
        done = 0;
        idle = 0;
        while (done < n && idle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #0.5;
            out_ready = random_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_transfer(check_class);
                done++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (done < n) begin
            $display("timeout: no transfer within %0d cycles, %0d of %0d taken",
                     TIMEOUT_CYCLES, done, n);
            errors++;
        end
    endtask

    // consumer stalls, the head must stay on the next expected word
    task automatic stall_output(input int cycles);
        @(posedge clk);
        #0.5;
        out_ready = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            assert (!out_valid || out_pc === exp_pc) else begin
                $display("[ERROR] out_pc: expected %h, got %h", exp_pc, out_pc);
                errors++;
            end
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_sequence();
        int start;
        start = errors;
        apply_reset();
        @(negedge clk);
        assert (out_valid === 1'b0) else begin
            $display("[ERROR] out_valid: expected 0, got %h", out_valid);
            errors++;
        end
        take_transfers(5, 1'b0, 1'b0);
        close_test("reset and sequence", start);
    endtask

    task automatic test_classification();
        int start;
        start = errors;
        apply_reset();
        take_transfers(30, 1'b0, 1'b1);
        close_test("classification", start);
    endtask

    task automatic test_jump_redirect();
        int start;
        start = errors;
        apply_reset();
        take_transfers(5, 1'b0, 1'b1);
        // let the jump and the words behind it pile up in the queue
        stall_output(20);
        take_transfers(7, 1'b0, 1'b1);
        assert (jumps_seen >= 2) else begin
            $display("jump test saw only %0d jumps", jumps_seen);
            errors++;
        end
        assert (filler_seen == 0) else begin
            $display("a word behind a jump was handed out %0d times", filler_seen);
            errors++;
        end
        close_test("jump redirect", start);
    endtask

    task automatic test_back_pressure();
        int start;
        int hold;
        start = errors;
        apply_reset();
        hold = $urandom_range(30, 5);
        stall_output(hold);
        take_transfers(40, 1'b1, 1'b1);
        close_test("back-pressure", start);
    endtask

    task automatic test_uncached_region();
        int start;
        start = errors;
        apply_reset();
        take_transfers(45, 1'b0, 1'b1);
        assert (uncached_seen >= 10) else begin
            $display("only %0d transfers came from the uncached region", uncached_seen);
            errors++;
        end
        close_test("uncached region", start);
    endtask

    initial begin
        rst = 1'b1;
        out_ready = 1'b0;
        exp_pc = RESET_PC;
        void'($urandom(32'h717e));
        $readmemh("tb/inst_rom.mem", image);

        test_reset_sequence();
        test_classification();
        test_jump_redirect();
        test_back_pressure();
        test_uncached_region();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/inst_rom.mem ====
// one 32-bit instruction word per entry in hex, from word index 0 upward
// opcode is bits 31:26, words 50xxxxxx to 53xxxxxx are direct jumps
00000001
28000002
40000003
fc000004
04000005
50000004
deadbeef deadbeef deadbeef
38000009
52000001 52000001 52000001 52000001 52000001 52000001 52000001
52000001 52000001 52000001 52000001 52000001 52000001 52000001
00000018
28000019
6800001a
53ffffe5

// ==== verilog.f ====
design/pipeline_types.sv
design/inst_rom.sv
design/icache.sv
design/fetch_unit.sv
design/inst_queue.sv
design/predecoder.sv
design/fetch_top.sv
tb/fetch_tb.sv
